// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [xlen/8-1:0] byte_mask_t;

    localparam word_t reset_pc    = 32'h8000_0000;
    localparam word_t ebreak_word = 32'h0010_0073;

    // major opcode classes, bits 6:0 of the instruction
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_eq, alu_ne
    } alu_op_t;

    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      reg_wen;
        logic      is_load;
        logic      is_store;
        mem_size_t mem_size;
        logic      load_unsigned;
        logic      wb_from_mem;
        logic      wb_from_pc4;
        logic      wb_from_imm;
        logic      is_branch;
        // taken when the compare result is zero
        logic      branch_on_zero;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
    } decoded_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        byte_mask_t wmask;
        logic       write;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_fetch, st_execute, st_memory, st_writeback, st_halted
    } core_state_t;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import rv_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [127:0] opcode_d;
    logic [7:0]   f3_d;
    logic [127:0] f7_d;

    // one-hot expansions of the opcode, funct3 and bits 31:25
    assign opcode_d = 128'd1 << inst[6:0];
    assign f3_d     = 8'd1 << inst[14:12];
    assign f7_d     = 128'd1 << inst[31:25];

    logic cls_op, cls_imm, cls_load, cls_store, cls_branch;
    logic is_lui, is_auipc, is_jal, is_jalr, is_ebreak;
    logic is_add, is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
    logic is_addi, is_xori, is_andi, is_sltiu, is_slli, is_srli, is_srai;
    logic is_lw, is_lh, is_lhu, is_lbu, is_sw, is_sh, is_sb;
    logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic is_load, is_store, is_branch;
    word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign cls_op     = opcode_d[opc_op];
    assign cls_imm    = opcode_d[opc_op_imm];
    assign cls_load   = opcode_d[opc_load];
    assign cls_store  = opcode_d[opc_store];
    assign cls_branch = opcode_d[opc_branch];

    assign is_lui    = opcode_d[opc_lui];
    assign is_auipc  = opcode_d[opc_auipc];
    assign is_jal    = opcode_d[opc_jal];
    assign is_jalr   = opcode_d[opc_jalr] & f3_d[0];
    assign is_ebreak = opcode_d[opc_system] & (inst == ebreak_word);

    // register ops, bit 30 picks sub and sra
    assign is_add  = cls_op & f3_d[0] & f7_d[0];
    assign is_sub  = cls_op & f3_d[0] & f7_d[32];
    assign is_sll  = cls_op & f3_d[1] & f7_d[0];
    assign is_slt  = cls_op & f3_d[2] & f7_d[0];
    assign is_sltu = cls_op & f3_d[3] & f7_d[0];
    assign is_xor  = cls_op & f3_d[4] & f7_d[0];
    assign is_srl  = cls_op & f3_d[5] & f7_d[0];
    assign is_sra  = cls_op & f3_d[5] & f7_d[32];
    assign is_or   = cls_op & f3_d[6] & f7_d[0];
    assign is_and  = cls_op & f3_d[7] & f7_d[0];

    assign is_addi  = cls_imm & f3_d[0];
    assign is_slli  = cls_imm & f3_d[1] & f7_d[0];
    assign is_sltiu = cls_imm & f3_d[3];
    assign is_xori  = cls_imm & f3_d[4];
    assign is_srli  = cls_imm & f3_d[5] & f7_d[0];
    assign is_srai  = cls_imm & f3_d[5] & f7_d[32];
    assign is_andi  = cls_imm & f3_d[7];

    assign is_lh  = cls_load & f3_d[1];
    assign is_lw  = cls_load & f3_d[2];
    assign is_lbu = cls_load & f3_d[4];
    assign is_lhu = cls_load & f3_d[5];
    assign is_sb  = cls_store & f3_d[0];
    assign is_sh  = cls_store & f3_d[1];
    assign is_sw  = cls_store & f3_d[2];

    assign is_beq  = cls_branch & f3_d[0];
    assign is_bne  = cls_branch & f3_d[1];
    assign is_blt  = cls_branch & f3_d[4];
    assign is_bge  = cls_branch & f3_d[5];
    assign is_bltu = cls_branch & f3_d[6];
    assign is_bgeu = cls_branch & f3_d[7];

    assign is_load   = is_lw | is_lh | is_lhu | is_lbu;
    assign is_store  = is_sw | is_sh | is_sb;
    assign is_branch = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec     = '0;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];
        dec.imm = ({xlen{cls_imm | cls_load | is_jalr}} & imm_i)
                | ({xlen{cls_store}} & imm_s)
                | ({xlen{cls_branch}} & imm_b)
                | ({xlen{is_lui | is_auipc}} & imm_u)
                | ({xlen{is_jal}} & imm_j);

        // branches borrow the compare ops, beq tests ne for zero
        if (is_sub)                               dec.alu_op = alu_sub;
        else if (is_sll | is_slli)                dec.alu_op = alu_sll;
        else if (is_slt | is_blt | is_bge)        dec.alu_op = alu_slt;
        else if (is_sltu | is_sltiu | is_bltu | is_bgeu) dec.alu_op = alu_sltu;
        else if (is_xor | is_xori)                dec.alu_op = alu_xor;
        else if (is_srl | is_srli)                dec.alu_op = alu_srl;
        else if (is_sra | is_srai)                dec.alu_op = alu_sra;
        else if (is_or)                           dec.alu_op = alu_or;
        else if (is_and | is_andi)                dec.alu_op = alu_and;
        else if (is_beq | is_bne)                 dec.alu_op = alu_ne;
        else                                      dec.alu_op = alu_add;

        dec.src1_is_pc  = is_auipc;
        dec.src2_is_imm = is_auipc | is_addi | is_xori | is_andi | is_sltiu
                        | is_slli | is_srli | is_srai;
        dec.reg_wen = is_lui | is_auipc | is_jal | is_jalr | is_load
                    | is_add | is_sub | is_sll | is_slt | is_sltu | is_xor
                    | is_srl | is_sra | is_or | is_and | dec.src2_is_imm;

        dec.is_load       = is_load;
        dec.is_store      = is_store;
        dec.mem_size      = (is_lbu | is_sb) ? size_byte :
                            (is_lh | is_lhu | is_sh) ? size_half : size_word;
        dec.load_unsigned = is_lbu | is_lhu;

        dec.wb_from_mem    = is_load;
        dec.wb_from_pc4    = is_jal | is_jalr;
        dec.wb_from_imm    = is_lui;
        dec.is_branch      = is_branch;
        dec.branch_on_zero = is_beq | is_bge | is_bgeu;
        dec.is_jal         = is_jal;
        dec.is_jalr        = is_jalr;
        dec.is_ebreak      = is_ebreak;
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu import rv_pkg::*; (
    input  word_t   src1,
    input  word_t   src2,
    input  alu_op_t op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_sll:  result = src1 << shamt;
            alu_slt:  result = word_t'($signed(src1) < $signed(src2));
            alu_sltu: result = word_t'(src1 < src2);
            alu_xor:  result = src1 ^ src2;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = word_t'($signed(src1) >>> shamt);
            alu_or:   result = src1 | src2;
            alu_and:  result = src1 & src2;
            // compare results are 1 or 0
            alu_eq:   result = word_t'(src1 == src2);
            alu_ne:   result = word_t'(src1 != src2);
            default:  result = '0;
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/100ps

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== source/mem_access_unit.sv ====
`timescale 1ns/100ps

module mem_access_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      is_fetch,
    input  word_t     addr,
    input  word_t     store_data,
    input  logic      is_store,
    input  mem_size_t size,
    input  logic      load_unsigned,
    output logic      done,
    output word_t     load_data,
    output mem_req_t  mem_req,
    output logic      req,
    input  logic      ack,
    input  word_t     rdata
);

    logic       pending;
    logic       launch;
    logic       fetch_q;
    logic       unsigned_q;
    mem_size_t  size_q;
    logic [1:0] lane_q;
    mem_req_t   next_req;
    word_t      shifted;
    word_t      extended;

    // a start waits here until the previous ack has gone low
    assign launch = !req && !ack && (start || pending);

    always_comb begin
        next_req.addr  = {addr[xlen-1:2], 2'b00};
        next_req.write = !is_fetch && is_store;
        case (size)
            size_byte: begin
                next_req.wdata = {4{store_data[7:0]}};
                next_req.wmask = 4'b0001 << addr[1:0];
            end
            size_half: begin
                next_req.wdata = {2{store_data[15:0]}};
                next_req.wmask = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                next_req.wdata = store_data;
                next_req.wmask = 4'b1111;
            end
        endcase
        if (!next_req.write) begin
            next_req.wmask = '0;
        end
    end

    // pick the addressed lane and extend it
    assign shifted = rdata >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            size_byte: extended = {{24{!unsigned_q & shifted[7]}}, shifted[7:0]};
            size_half: extended = {{16{!unsigned_q & shifted[15]}}, shifted[15:0]};
            default:   extended = rdata;
        endcase
        if (fetch_q) begin
            extended = rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req     <= 1'b0;
            done    <= 1'b0;
            pending <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                req     <= 1'b1;
                pending <= 1'b0;
            end else if (start) begin
                pending <= 1'b1;
            end
            if (req && ack) begin
                req  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // request payload only changes at launch, while req and ack are low
    always_ff @(posedge clk) begin
        if (launch) begin
            mem_req    <= next_req;
            fetch_q    <= is_fetch;
            unsigned_q <= load_unsigned;
            size_q     <= size;
            lane_q     <= addr[1:0];
        end
        if (req && ack) begin
            load_data <= extended;
        end
    end

endmodule

// ==== source/core_control.sv ====
`timescale 1ns/100ps

module core_control import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  decoded_t dec,
    input  word_t    alu_result,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  logic     mem_done,
    input  word_t    load_data,
    output word_t    inst,
    output word_t    alu_src1,
    output word_t    alu_src2,
    output logic     rf_wen,
    output word_t    rf_wdata,
    output logic     mem_start,
    output logic     mem_is_fetch,
    output word_t    mem_addr,
    output word_t    mem_store_data,
    output word_t    pc,
    output logic     halted
);

    core_state_t state;
    logic        issued;
    logic        branch_taken;
    word_t       pc_plus4;
    word_t       next_pc;

    assign pc_plus4 = pc + 32'd4;

    assign alu_src1 = dec.src1_is_pc ? pc : rs1_data;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rs2_data;

    assign branch_taken = dec.is_branch &&
                          (dec.branch_on_zero ? (alu_result == '0) : (alu_result != '0));

    assign next_pc = dec.is_jalr ? ((rs1_data + dec.imm) & ~word_t'(1)) :
                     (dec.is_jal || branch_taken) ? pc + dec.imm :
                     pc_plus4;

    // one start per bus transaction
    assign mem_start      = (state == st_fetch || state == st_memory) && !issued;
    assign mem_is_fetch   = (state == st_fetch);
    assign mem_addr       = mem_is_fetch ? pc : rs1_data + dec.imm;
    assign mem_store_data = rs2_data;

    assign rf_wen   = (state == st_writeback) && dec.reg_wen;
    assign rf_wdata = dec.wb_from_mem ? load_data :
                      dec.wb_from_pc4 ? pc_plus4 :
                      dec.wb_from_imm ? dec.imm :
                      alu_result;

    assign halted = (state == st_halted);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_fetch;
            pc     <= reset_pc;
            issued <= 1'b0;
        end else begin
            if (mem_start) begin
                issued <= 1'b1;
            end else if (mem_done) begin
                issued <= 1'b0;
            end
            case (state)
                st_fetch: begin
                    if (mem_done) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (dec.is_ebreak) begin
                        state <= st_halted;
                    end else if (dec.is_load || dec.is_store) begin
                        state <= st_memory;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_memory: begin
                    if (mem_done) begin
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    pc    <= next_pc;
                    state <= st_fetch;
                end
                // stays halted until reset
                default: state <= st_halted;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == st_fetch && mem_done) begin
            inst <= load_data;
        end
    end

endmodule

// ==== source/npc_core.sv ====
`timescale 1ns/100ps

module npc_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output mem_req_t mem_req,
    output logic     req,
    input  logic     ack,
    input  word_t    rdata,
    output logic     halted,
    output word_t    pc
);

    word_t    inst;
    decoded_t dec;
    word_t    alu_src1;
    word_t    alu_src2;
    word_t    alu_result;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     rf_wen;
    word_t    rf_wdata;
    logic     mem_start;
    logic     mem_is_fetch;
    word_t    mem_addr;
    word_t    mem_store_data;
    logic     mem_done;
    word_t    load_data;

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    alu alu_i (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    register_file register_file_i (
        .clk    (clk),
        .wen    (rf_wen),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    mem_access_unit mem_access_unit_i (
        .clk           (clk),
        .reset         (reset),
        .start         (mem_start),
        .is_fetch      (mem_is_fetch),
        .addr          (mem_addr),
        .store_data    (mem_store_data),
        .is_store      (dec.is_store),
        .size          (dec.mem_size),
        .load_unsigned (dec.load_unsigned),
        .done          (mem_done),
        .load_data     (load_data),
        .mem_req       (mem_req),
        .req           (req),
        .ack           (ack),
        .rdata         (rdata)
    );

    core_control core_control_i (
        .clk            (clk),
        .reset          (reset),
        .dec            (dec),
        .alu_result     (alu_result),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .mem_done       (mem_done),
        .load_data      (load_data),
        .inst           (inst),
        .alu_src1       (alu_src1),
        .alu_src2       (alu_src2),
        .rf_wen         (rf_wen),
        .rf_wdata       (rf_wdata),
        .mem_start      (mem_start),
        .mem_is_fetch   (mem_is_fetch),
        .mem_addr       (mem_addr),
        .mem_store_data (mem_store_data),
        .pc             (pc),
        .halted         (halted)
    );

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 10 ns period
    always #5 clk = ~clk;

endmodule

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/100ps

module tb_mem_model import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    input  logic     req,
    output logic     ack,
    output word_t    rdata
);

    localparam int mem_bytes = 8192;

    // byte image, offset is the low 13 address bits
    logic [7:0]  mem [mem_bytes];
    logic [31:0] lcg_state;
    logic        waiting;
    int          delay;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic serve_request();
        int off;
        off = int'(mem_req.addr[12:0]);
        if (mem_req.write) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_req.wmask[k]) begin
                    mem[off + k] = mem_req.wdata[8*k +: 8];
                end
            end
        end
        rdata <= {mem[off + 3], mem[off + 2], mem[off + 1], mem[off]};
    endtask

    initial begin
        ack       = 1'b0;
        rdata     = '0;
        lcg_state = 32'd32223;
        waiting   = 1'b0;
        delay     = 0;
    end

    // responder side of the four-phase handshake
    // ack follows req after 0 to 3 cycles, on both the rising and the falling edge
    always @(negedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            waiting = 1'b0;
        end else if (req != ack) begin
            if (!waiting) begin
                lcg_state = lcg_next(lcg_state);
                delay = int'(lcg_state[17:16]);
                waiting = 1'b1;
            end
            if (delay == 0) begin
                if (req) begin
                    serve_request();
                end
                ack <= req;
                waiting = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end
    end

endmodule

// ==== tests/tb_npc.sv ====
`timescale 1ns/100ps

module tb_npc import rv_pkg::*; ();

    localparam int reset_cycles    = 10;
    // program area ends where the result area starts
    localparam int prog_words_max  = 1000;
    // two bus transactions of up to 8 cycles each, plus execute and writeback
    localparam int worst_cpi       = 20;
    localparam int watchdog_cycles = prog_words_max * worst_cpi;
    localparam int mem_bytes       = 8192;
    localparam int result_off      = 'h1000;
    localparam int data_off        = 'h1800;
    localparam word_t result_base  = 32'h8000_1000;
    localparam word_t data_base    = 32'h8000_1800;

    // operands loaded by the program
    localparam word_t op_a = 32'h8765_4321;
    localparam word_t op_b = 32'h0000_0013;
    localparam word_t op_c = 32'hFFFF_FF9C;
    localparam word_t op_d = 32'h0000_0039;

    logic       clk;
    logic       reset;
    mem_req_t   mem_req;
    logic       req;
    logic       ack;
    word_t      rdata;
    logic       halted;
    word_t      pc;
    word_t      prog [$];
    word_t      expect_q [$];
    logic [7:0] data_img [16];
    word_t      ebreak_pc;
    logic       prev_req;
    logic       prev_ack;
    mem_req_t   prev_mem_req;

    clock_gen clock_gen_i (.clk(clk));

    tb_mem_model mem_model_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .req     (req),
        .ack     (ack),
        .rdata   (rdata)
    );

    npc_core npc_core_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .req     (req),
        .ack     (ack),
        .rdata   (rdata),
        .halted  (halted),
        .pc      (pc)
    );

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // instruction formats
    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t i_type(word_t imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(word_t imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(word_t imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(word_t imm, reg_addr_t rd, logic [6:0] opc);
        return {imm[31:12], rd, opc};
    endfunction

    function automatic word_t j_type(word_t imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic word_t here();
        return reset_pc + word_t'(4 * prog.size());
    endfunction

    function automatic word_t get_word(int off);
        return {mem_model_i.mem[off + 3], mem_model_i.mem[off + 2],
                mem_model_i.mem[off + 1], mem_model_i.mem[off]};
    endfunction

    function automatic logic branch_rule(logic [2:0] f3, word_t x, word_t y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            default: return x >= y;
        endcase
    endfunction

    // load result from the expected data image
    function automatic word_t image_value(logic [2:0] f3, int off);
        logic [15:0] half;
        half = {data_img[off + 1], data_img[off]};
        case (f3)
            3'd1:    return {{16{half[15]}}, half};
            3'd2:    return {data_img[off + 3], data_img[off + 2], half};
            3'd4:    return {24'd0, data_img[off]};
            default: return {16'd0, half};
        endcase
    endfunction

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    task automatic put_word(int off, word_t w);
        for (int k = 0; k < 4; k++) begin
            mem_model_i.mem[off + k] = w[8*k +: 8];
        end
    endtask

    // sw into the next result slot
    task automatic store_check(reg_addr_t r, word_t expected);
        emit(s_type(word_t'(4 * expect_q.size()), r, 5'd9, 3'd2));
        expect_q.push_back(expected);
    endtask

    task automatic load_const(reg_addr_t rd, word_t v);
        word_t upper;
        upper = v + 32'h800;
        emit(u_type({upper[31:12], 12'b0}, rd, opc_lui));
        emit(i_type(v, rd, 3'd0, rd, opc_op_imm));
    endtask

    task automatic reg_op(logic [6:0] f7, logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                          word_t expected);
        emit(r_type(f7, rs2, rs1, f3, 5'd3, opc_op));
        store_check(5'd3, expected);
    endtask

    task automatic imm_op(logic [2:0] f3, word_t imm, reg_addr_t rs1, word_t expected);
        emit(i_type(imm, rs1, f3, 5'd3, opc_op_imm));
        store_check(5'd3, expected);
    endtask

    task automatic store_op(logic [2:0] f3, reg_addr_t rs2, int off, word_t value);
        int nbytes;
        nbytes = 1 << f3;
        emit(s_type(word_t'(off), rs2, 5'd8, f3));
        for (int k = 0; k < nbytes; k++) begin
            data_img[off + k] = value[8*k +: 8];
        end
    endtask

    task automatic load_op(logic [2:0] f3, int off);
        emit(i_type(word_t'(off), 5'd8, f3, 5'd3, opc_load));
        store_check(5'd3, image_value(f3, off));
    endtask

    // x20 ends up 2 on the taken path, 1 otherwise
    task automatic branch_case(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                               word_t x, word_t y);
        emit(b_type(32'd12, rs2, rs1, f3));
        emit(i_type(32'd1, 5'd0, 3'd0, 5'd20, opc_op_imm));
        emit(j_type(32'd8, 5'd0));
        emit(i_type(32'd2, 5'd0, 3'd0, 5'd20, opc_op_imm));
        store_check(5'd20, branch_rule(f3, x, y) ? 32'd2 : 32'd1);
    endtask

    task automatic fill_memory();
        logic [12:0] a;
        for (int i = 0; i < mem_bytes; i++) begin
            a = 13'(i);
            mem_model_i.mem[i] = a[7:0] ^ {3'b000, a[12:8]};
        end
    endtask

    task automatic init_data();
        word_t init_words [4];
        init_words = '{32'h8899_AABB, 32'h5566_7788, 32'h0123_4567, 32'hC3C2_C1C0};
        for (int i = 0; i < 4; i++) begin
            put_word(data_off + 4 * i, init_words[i]);
            for (int k = 0; k < 4; k++) begin
                data_img[4 * i + k] = init_words[i][8*k +: 8];
            end
        end
    endtask

    task automatic build_program();
        word_t      p;
        logic [2:0] br_f3 [6];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        load_const(5'd9, result_base);
        load_const(5'd8, data_base);
        load_const(5'd1, op_a);
        load_const(5'd2, op_b);
        load_const(5'd4, op_c);
        load_const(5'd5, op_d);

        reg_op(7'h00, 3'd0, 5'd1, 5'd2, op_a + op_b);
        reg_op(7'h20, 3'd0, 5'd1, 5'd2, op_a - op_b);
        reg_op(7'h00, 3'd1, 5'd1, 5'd2, op_a << op_b[4:0]);
        reg_op(7'h00, 3'd2, 5'd1, 5'd2, word_t'($signed(op_a) < $signed(op_b)));
        reg_op(7'h00, 3'd3, 5'd1, 5'd2, word_t'(op_a < op_b));
        reg_op(7'h00, 3'd4, 5'd1, 5'd2, op_a ^ op_b);
        reg_op(7'h00, 3'd5, 5'd1, 5'd2, op_a >> op_b[4:0]);
        reg_op(7'h20, 3'd5, 5'd1, 5'd2, word_t'($signed(op_a) >>> op_b[4:0]));
        reg_op(7'h00, 3'd6, 5'd1, 5'd2, op_a | op_b);
        reg_op(7'h00, 3'd7, 5'd1, 5'd2, op_a & op_b);
        reg_op(7'h00, 3'd2, 5'd4, 5'd5, word_t'($signed(op_c) < $signed(op_d)));
        reg_op(7'h00, 3'd3, 5'd4, 5'd5, word_t'(op_c < op_d));

        imm_op(3'd0, 32'hFFFF_FFFB, 5'd1, op_a + 32'hFFFF_FFFB);
        imm_op(3'd4, 32'h0000_07FF, 5'd1, op_a ^ 32'h0000_07FF);
        imm_op(3'd7, 32'hFFFF_FF00, 5'd1, op_a & 32'hFFFF_FF00);
        imm_op(3'd3, 32'd100, 5'd2, word_t'(op_b < 32'd100));
        imm_op(3'd3, 32'd5, 5'd1, word_t'(op_a < 32'd5));
        imm_op(3'd1, 32'd7, 5'd1, op_a << 7);
        imm_op(3'd5, 32'd9, 5'd1, op_a >> 9);
        imm_op(3'd5, 32'h409, 5'd1, word_t'($signed(op_a) >>> 9));

        emit(u_type(32'hABCD_E000, 5'd6, opc_lui));
        store_check(5'd6, 32'hABCD_E000);
        p = here();
        emit(u_type(32'h0001_2000, 5'd7, opc_auipc));
        store_check(5'd7, p + 32'h0001_2000);
        // writes to x0 are dropped
        emit(i_type(32'd5, 5'd1, 3'd0, 5'd0, opc_op_imm));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, opc_op));
        store_check(5'd0, 32'd0);

        store_op(3'd0, 5'd1, 1, op_a);
        store_op(3'd1, 5'd1, 6, op_a);
        store_op(3'd2, 5'd4, 8, op_c);
        store_op(3'd0, 5'd5, 14, op_d);
        load_op(3'd2, 0);
        load_op(3'd1, 2);
        load_op(3'd1, 6);
        load_op(3'd5, 10);
        load_op(3'd1, 8);
        load_op(3'd4, 8);
        load_op(3'd4, 1);
        load_op(3'd2, 12);
        load_op(3'd4, 14);

        foreach (br_f3[i]) begin
            branch_case(br_f3[i], 5'd4, 5'd5, op_c, op_d);
            if (br_f3[i] < 3'd2) begin
                branch_case(br_f3[i], 5'd5, 5'd5, op_d, op_d);
            end else begin
                branch_case(br_f3[i], 5'd5, 5'd4, op_d, op_c);
            end
        end

        emit(i_type(32'h55, 5'd0, 3'd0, 5'd13, opc_op_imm));
        p = here();
        emit(j_type(32'd8, 5'd12));
        emit(i_type(32'h66, 5'd0, 3'd0, 5'd13, opc_op_imm));
        store_check(5'd12, p + 32'd4);
        store_check(5'd13, 32'h55);
        // odd jalr target, bit 0 must be cleared
        emit(i_type(32'h77, 5'd0, 3'd0, 5'd13, opc_op_imm));
        p = here() + 32'd8;
        load_const(5'd14, p + 32'd5);
        emit(i_type(32'd4, 5'd14, 3'd0, 5'd15, opc_jalr));
        emit(i_type(32'h88, 5'd0, 3'd0, 5'd13, opc_op_imm));
        store_check(5'd15, p + 32'd4);
        store_check(5'd13, 32'h77);

        ebreak_pc = here();
        emit(ebreak_word);
    endtask

    task automatic check_results();
        word_t got;
        for (int i = 0; i < expect_q.size(); i++) begin
            got = get_word(result_off + 4 * i);
            assert (got == expect_q[i]) else
                fail_run($sformatf("Mismatch at %0t: result %0d expected %08h got %08h",
                                   $time, i, expect_q[i], got));
        end
        for (int i = 0; i < 16; i++) begin
            assert (mem_model_i.mem[data_off + i] == data_img[i]) else
                fail_run($sformatf("Mismatch at %0t: data byte %0d expected %02h got %02h",
                                   $time, i, data_img[i], mem_model_i.mem[data_off + i]));
        end
    endtask

    // bus protocol, sampled as the DUT sees it
    always @(posedge clk) begin
        if (!reset) begin
            assert (!(req && !prev_req && prev_ack)) else
                fail_run($sformatf("Handshake error at %0t: req rose while ack was high",
                                   $time));
            assert (!(prev_req || prev_ack) || mem_req == prev_mem_req) else
                fail_run($sformatf("Handshake error at %0t: request changed during a transfer",
                                   $time));
            assert (!(halted && req)) else
                fail_run($sformatf("Bus error at %0t: req raised after the core halted",
                                   $time));
        end
        prev_req     = req;
        prev_ack     = ack;
        prev_mem_req = mem_req;
    end

    initial begin
        repeat (reset_cycles + watchdog_cycles) @(posedge clk);
        fail_run($sformatf("Timeout: core did not halt within %0d cycles", watchdog_cycles));
    end

    initial begin
        reset        = 1'b1;
        prev_req     = 1'b0;
        prev_ack     = 1'b0;
        prev_mem_req = '0;
        fill_memory();
        init_data();
        build_program();
        assert (prog.size() <= prog_words_max) else
            fail_run("Program does not fit in the program area");
        for (int i = 0; i < prog.size(); i++) begin
            put_word(4 * i, prog[i]);
        end

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end

        assert (pc == ebreak_pc) else
            fail_run($sformatf("Mismatch at %0t: halt pc expected %08h got %08h",
                               $time, ebreak_pc, pc));
        check_results();
        // the monitor keeps watching req while the core sits halted
        repeat (20) begin
            @(negedge clk);
            assert (halted && !req) else
                fail_run($sformatf("Halt error at %0t: core left the halted state", $time));
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
source/rv_pkg.sv
source/inst_decoder.sv
source/alu.sv
source/register_file.sv
source/mem_access_unit.sv
source/core_control.sv
source/npc_core.sv
tests/clock_gen.sv
tests/tb_mem_model.sv
tests/tb_npc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_npc -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_npc > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
